// File: src/maPkg.sv
// Multiply-add unit shared types
// Data, tag, product and operation encodings used across the datapath

package maPkg;

	////////////////////////////////////////
	// Widths

	localparam int DATA_WIDTH = 16;		// Integer operand width
	localparam int TAG_WIDTH = 4;		// Issue tag width, wraps

	////////////////////////////////////////
	// Value types

	// Operand and result value, wraps modulo 2^16
	typedef logic [DATA_WIDTH-1:0] maData;

	// Issue tag attached to every accepted operation
	typedef logic [TAG_WIDTH-1:0] maTag;

	// Low half of the multiplier product
	typedef logic [DATA_WIDTH-1:0] maProduct;

	////////////////////////////////////////
	// Operation encoding

	typedef enum logic [1:0] {
		opAdd = 2'b00,		// A plus B
		opSub = 2'b01,		// A minus B
		opMul = 2'b10,		// A times B
		opMad = 2'b11		// A times B plus C
	} maOp;

endpackage

// File: src/maLaneIf.sv
// Operand and result lane between the multiply-add blocks
// One tagged operation or result per cycle, qualified by valid

`timescale 1ns/1ns

interface maLaneIf;
	import maPkg::*;

	logic valid;		// Lane carries an item this cycle
	maData a;			// First operand or result value
	maData b;			// Second operand, zero on result lanes
	maTag tag;			// Issue tag of the item
	maOp op;			// Operation the item belongs to

	modport source (
		output valid,
		output a,
		output b,
		output tag,
		output op
	);

	modport sink (
		input valid,
		input a,
		input b,
		input tag,
		input op
	);

endinterface

// File: src/maIssue.sv
// Multiply-add issue stage
// Decodes operations, reserves adder entry and result cycles ahead of time,
// raises busy on a collision and launches accepted work onto the lanes

`timescale 1ns/1ns

module maIssue #(
	parameter int DEPTH_MLT = 3,
	parameter int DEPTH_ADD = 1
)(
	input logic clock,
	input logic arstN,
	input logic opStrobe,
	input maPkg::maOp opCode,
	input maPkg::maData opA,
	input maPkg::maData opB,
	input maPkg::maData opC,
	output logic busy,
	output maPkg::maTag issueTag,
	maLaneIf.source multLane,
	maLaneIf.source addLane,
	output logic ringPush,
	output maPkg::maData ringData
);
	import maPkg::*;

	// Slot i is the cycle i edges after the upcoming one
	localparam int ADD_LEN = DEPTH_MLT + 2;
	localparam int RES_LEN = DEPTH_MLT + DEPTH_ADD + 2;

	logic [ADD_LEN-1:0] addRes;		// Taken adder entry slots
	logic [ADD_LEN-1:0] addMark;	// Slot wanted by presented op
	logic [RES_LEN-1:0] resRes;		// Taken result slots
	logic [RES_LEN-1:0] resMark;
	logic accept;
	logic toMult;
	logic multValid;
	logic addValid;
	maTag tagCnt;
	maData aQ;
	maData bQ;
	maData cQ;
	maTag tagQ;
	maOp opQ;

	// Offsets follow the fixed pipe latencies
	always_comb begin
		addMark = '0;
		resMark = '0;
		case (opCode)
			opAdd, opSub: begin
				addMark[1] = 1'b1;
				resMark[DEPTH_ADD + 1] = 1'b1;
			end
			opMul: resMark[DEPTH_MLT + 1] = 1'b1;		// Never touches the adder
			opMad: begin
				addMark[DEPTH_MLT + 1] = 1'b1;			// Chained product arrives
				resMark[DEPTH_MLT + DEPTH_ADD + 1] = 1'b1;
			end
		endcase
	end

	assign busy = opStrobe & ((|(addMark & addRes)) | (|(resMark & resRes)));
	assign accept = opStrobe & ~busy;
	assign toMult = (opCode == opMul) || (opCode == opMad);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			addRes <= '0;
			resRes <= '0;
			tagCnt <= '0;
			multValid <= 1'b0;
			addValid <= 1'b0;
			ringPush <= 1'b0;
		end else begin
			addRes <= (addRes | ({ADD_LEN{accept}} & addMark)) >> 1;	// Advance one cycle
			resRes <= (resRes | ({RES_LEN{accept}} & resMark)) >> 1;
			if (accept)
				tagCnt <= maTag'(tagCnt + 1'b1);
			multValid <= accept & toMult;
			addValid <= accept & ~toMult;
			ringPush <= accept & (opCode == opMad);		// Third operand waits in ring
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			aQ <= opA;
			bQ <= opB;
			cQ <= opC;
			tagQ <= tagCnt;
			opQ <= opCode;
		end
	end

	assign issueTag = tagCnt;
	assign ringData = cQ;

	// Both lanes share the launch register
	assign multLane.valid = multValid;
	assign multLane.a = aQ;
	assign multLane.b = bQ;
	assign multLane.tag = tagQ;
	assign multLane.op = opQ;

	assign addLane.valid = addValid;
	assign addLane.a = aQ;
	assign addLane.b = bQ;
	assign addLane.tag = tagQ;
	assign addLane.op = opQ;

	// A refused operation stays on the inputs until taken
	assert property (@(posedge clock) disable iff (!arstN)
		busy |=> opStrobe && $stable(opCode) && $stable(opA) && $stable(opB) && $stable(opC))
		else $error("maIssue: operation withdrawn or changed while busy");

endmodule

// File: src/maOperandRing.sv
// Third-operand ring buffer for multiply-add
// Holds C operands in issue order until the matching product reaches the adder

`timescale 1ns/1ns

module maOperandRing #(
	parameter int DEPTH_MLT = 3
)(
	input logic clock,
	input logic arstN,
	input logic push,
	input maPkg::maData pushData,
	input logic pop,
	output maPkg::maData headData
);
	import maPkg::*;

	localparam int PTR_W = $clog2(DEPTH_MLT);
	localparam int CNT_W = $clog2(DEPTH_MLT + 1);

	maData mem [DEPTH_MLT];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;		// Entries held

	always_ff @(posedge clock) begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == PTR_W'(DEPTH_MLT - 1)) ? '0 : PTR_W'(wrPtr + 1'b1);
			if (pop)
				rdPtr <= (rdPtr == PTR_W'(DEPTH_MLT - 1)) ? '0 : PTR_W'(rdPtr + 1'b1);
			case ({push, pop})
				2'b10: count <= CNT_W'(count + 1'b1);
				2'b01: count <= CNT_W'(count - 1'b1);
				default: count <= count;		// Idle or push with pop
			endcase
		end
	end

	assign headData = mem[rdPtr];

	assert property (@(posedge clock) disable iff (!arstN)
		push |-> (count < CNT_W'(DEPTH_MLT)) || pop)
		else $error("maOperandRing: push while full");

	assert property (@(posedge clock) disable iff (!arstN)
		pop |-> (count != '0))
		else $error("maOperandRing: pop while empty");

endmodule

// File: src/maMultPipe.sv
// Integer multiplier pipeline
// Multiplies in the first stage, carries tag and op through DEPTH_MLT stages
// and steers the last stage to the result lane or the adder chain

`timescale 1ns/1ns

module maMultPipe #(
	parameter int DEPTH_MLT = 3
)(
	input logic clock,
	input logic arstN,
	maLaneIf.sink inLane,
	maLaneIf.source resultLane,
	maLaneIf.source chainLane
);
	import maPkg::*;

	localparam int LAST = DEPTH_MLT - 1;

	maProduct product;
	maProduct prodQ [DEPTH_MLT];
	maTag tagQ [DEPTH_MLT];
	maOp opQ [DEPTH_MLT];
	logic [DEPTH_MLT-1:0] validQ;
	logic lastIsMad;

	assign product = maProduct'(inLane.a * inLane.b);	// Low half only

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			validQ <= '0;
		end else begin
			validQ[0] <= inLane.valid;
			for (int i = 1; i < DEPTH_MLT; i++)
				validQ[i] <= validQ[i-1];
		end
	end

	always_ff @(posedge clock) begin
		prodQ[0] <= product;
		tagQ[0] <= inLane.tag;
		opQ[0] <= inLane.op;
		for (int i = 1; i < DEPTH_MLT; i++) begin
			prodQ[i] <= prodQ[i-1];
			tagQ[i] <= tagQ[i-1];
			opQ[i] <= opQ[i-1];
		end
	end

	assign lastIsMad = (opQ[LAST] == opMad);

	assign resultLane.valid = validQ[LAST] & ~lastIsMad;	// Plain multiply finishes
	assign resultLane.a = prodQ[LAST];
	assign resultLane.b = '0;
	assign resultLane.tag = tagQ[LAST];
	assign resultLane.op = opQ[LAST];

	assign chainLane.valid = validQ[LAST] & lastIsMad;		// On to the adder
	assign chainLane.a = prodQ[LAST];
	assign chainLane.b = '0;
	assign chainLane.tag = tagQ[LAST];
	assign chainLane.op = opQ[LAST];

endmodule

// File: src/maAddPipe.sv
// Integer adder pipeline
// Takes a chained product plus ring operand, or a direct add or subtract,
// and carries the sum through DEPTH_ADD stages

`timescale 1ns/1ns

module maAddPipe #(
	parameter int DEPTH_ADD = 1
)(
	input logic clock,
	input logic arstN,
	maLaneIf.sink addLane,
	maLaneIf.sink chainLane,
	output logic ringPop,
	input maPkg::maData ringHead,
	maLaneIf.source resultLane
);
	import maPkg::*;

	localparam int LAST = DEPTH_ADD - 1;

	logic useChain;
	maData opndA;
	maData opndB;
	maData sum;
	maTag inTag;
	maOp inOp;
	maData sumQ [DEPTH_ADD];
	maTag tagQ [DEPTH_ADD];
	maOp opQ [DEPTH_ADD];
	logic [DEPTH_ADD-1:0] validQ;

	assign useChain = chainLane.valid;
	assign ringPop = useChain;		// Head belongs to this product
	assign opndA = useChain ? chainLane.a : addLane.a;
	assign opndB = useChain ? ringHead : addLane.b;
	assign inTag = useChain ? chainLane.tag : addLane.tag;
	assign inOp = useChain ? chainLane.op : addLane.op;
	assign sum = (inOp == opSub) ? maData'(opndA - opndB) : maData'(opndA + opndB);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			validQ <= '0;
		end else begin
			validQ[0] <= useChain | addLane.valid;
			for (int i = 1; i < DEPTH_ADD; i++)
				validQ[i] <= validQ[i-1];
		end
	end

	always_ff @(posedge clock) begin
		sumQ[0] <= sum;
		tagQ[0] <= inTag;
		opQ[0] <= inOp;
		for (int i = 1; i < DEPTH_ADD; i++) begin
			sumQ[i] <= sumQ[i-1];
			tagQ[i] <= tagQ[i-1];
			opQ[i] <= opQ[i-1];
		end
	end

	assign resultLane.valid = validQ[LAST];
	assign resultLane.a = sumQ[LAST];
	assign resultLane.b = '0;
	assign resultLane.tag = tagQ[LAST];
	assign resultLane.op = opQ[LAST];

	// Issue reservation keeps adder entries unique
	assert property (@(posedge clock) disable iff (!arstN)
		!(addLane.valid && chainLane.valid))
		else $error("maAddPipe: direct and chained operands collide");

endmodule

// File: src/maResultSelect.sv
// Result port of the multiply-add unit
// Registers the finished result from whichever pipe has one this cycle

`timescale 1ns/1ns

module maResultSelect (
	input logic clock,
	input logic arstN,
	maLaneIf.sink multResult,
	maLaneIf.sink addResult,
	output logic resultValid,
	output maPkg::maData resultData,
	output maPkg::maTag resultTag
);
	import maPkg::*;

	maData nextData;
	maTag nextTag;

	assign nextData = multResult.valid ? multResult.a : addResult.a;
	assign nextTag = multResult.valid ? multResult.tag : addResult.tag;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			resultValid <= 1'b0;
		else
			resultValid <= multResult.valid | addResult.valid;	// One-cycle pulse
	end

	always_ff @(posedge clock) begin
		resultData <= nextData;
		resultTag <= nextTag;
	end

	// Result slots were reserved at issue, several cycles back
	assert property (@(posedge clock) disable iff (!arstN)
		!(multResult.valid && addResult.valid))
		else $error("maResultSelect: both pipes finished in the same cycle");

endmodule

// File: src/maUnit.sv
// Fused multiply-add execution unit, top level
// One operation in per cycle on a strobe, one tagged result out per cycle,
// multiplier and adder pipes chained for multiply-add

`timescale 1ns/1ns

module maUnit #(
	parameter int DEPTH_MLT = 3,
	parameter int DEPTH_ADD = 1
)(
	input logic clock,
	input logic arstN,
	input logic opStrobe,
	input maPkg::maOp opCode,
	input maPkg::maData opA,
	input maPkg::maData opB,
	input maPkg::maData opC,
	output logic busy,
	output maPkg::maTag issueTag,
	output logic resultValid,
	output maPkg::maData resultData,
	output maPkg::maTag resultTag
);
	import maPkg::*;

	logic ringPush;
	logic ringPop;
	maData ringData;
	maData ringHead;

	////////////////////////////////////////
	// Lanes

	maLaneIf multLane ();		// Issue to multiplier
	maLaneIf addLane ();		// Issue to adder
	maLaneIf chainLane ();		// Product into adder
	maLaneIf multResLane ();
	maLaneIf addResLane ();

	////////////////////////////////////////
	// Blocks

	maIssue #(
		.DEPTH_MLT(DEPTH_MLT),
		.DEPTH_ADD(DEPTH_ADD)
	) maIssue_inst (
		.clock(clock),
		.arstN(arstN),
		.opStrobe(opStrobe),
		.opCode(opCode),
		.opA(opA),
		.opB(opB),
		.opC(opC),
		.busy(busy),
		.issueTag(issueTag),
		.multLane(multLane.source),
		.addLane(addLane.source),
		.ringPush(ringPush),
		.ringData(ringData)
	);

	maOperandRing #(
		.DEPTH_MLT(DEPTH_MLT)
	) maOperandRing_inst (
		.clock(clock),
		.arstN(arstN),
		.push(ringPush),
		.pushData(ringData),
		.pop(ringPop),
		.headData(ringHead)
	);

	maMultPipe #(
		.DEPTH_MLT(DEPTH_MLT)
	) maMultPipe_inst (
		.clock(clock),
		.arstN(arstN),
		.inLane(multLane.sink),
		.resultLane(multResLane.source),
		.chainLane(chainLane.source)
	);

	maAddPipe #(
		.DEPTH_ADD(DEPTH_ADD)
	) maAddPipe_inst (
		.clock(clock),
		.arstN(arstN),
		.addLane(addLane.sink),
		.chainLane(chainLane.sink),
		.ringPop(ringPop),
		.ringHead(ringHead),
		.resultLane(addResLane.source)
	);

	maResultSelect maResultSelect_inst (
		.clock(clock),
		.arstN(arstN),
		.multResult(multResLane.sink),
		.addResult(addResLane.sink),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultTag(resultTag)
	);

endmodule

// File: verification/maUnitTb.sv
// Testbench for the fused multiply-add unit
// Random and directed operations, per-tag expected results, a reference model
// of the cycle reservation for busy, and a watchdog

`timescale 1ns/1ns

module maUnitTb;
	import maPkg::*;

	localparam int DEPTH_MLT = 3;
	localparam int DEPTH_ADD = 1;
	localparam int CLK_PERIOD = 100;
	localparam int NUM_OPS = 600;
	localparam int WATCHDOG_NS = (16 + (NUM_OPS + 8) * (DEPTH_MLT + DEPTH_ADD + 4) + 100)
		* CLK_PERIOD;

	logic clock = 1'b0;
	logic arstN;
	logic opStrobe;
	maOp opCode;
	maData opA;
	maData opB;
	maData opC;
	logic busy;
	maTag issueTag;
	logic resultValid;
	maData resultData;
	maTag resultTag;

	integer seed = 32'h154;
	int cyc = 0;				// Negedge count since reset release
	int seqCnt = 0;
	maTag nextTag = '0;
	bit sawReorder = 1'b0;
	bit addTaken [int];			// Absolute cycles with the adder entry taken
	bit resTaken [int];			// Absolute cycles with the result port taken
	bit pendValid [16];
	maData pendData [16];
	int pendDue [16];
	int pendSeq [16];

	maUnit #(
		.DEPTH_MLT(DEPTH_MLT),
		.DEPTH_ADD(DEPTH_ADD)
	) maUnit_inst (
		.clock(clock),
		.arstN(arstN),
		.opStrobe(opStrobe),
		.opCode(opCode),
		.opA(opA),
		.opB(opB),
		.opC(opC),
		.busy(busy),
		.issueTag(issueTag),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultTag(resultTag)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	////////////////////////////////////////
	// Reference rules

	function automatic maData expectedResult(maOp op, maData a, maData b, maData c);
		logic [31:0] full;
		case (op)
			opAdd: full = a + b;
			opSub: full = a - b;
			opMul: full = a * b;
			default: full = a * b + c;
		endcase
		return full[15:0];				// Wraps modulo 2^16
	endfunction

	function automatic int latencyOf(maOp op);
		case (op)
			opAdd, opSub: return DEPTH_ADD + 1;
			opMul: return DEPTH_MLT + 1;
			default: return DEPTH_MLT + DEPTH_ADD + 1;
		endcase
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic reportMismatch(input string sigName, input logic [31:0] expVal,
			input logic [31:0] actVal);
		failRun($sformatf("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
			$time, sigName, expVal, actVal));
	endtask

	////////////////////////////////////////
	// Per-cycle checking and driving

	task automatic checkResults();
		maTag t;
		if (resultValid) begin
			t = resultTag;
			assert (pendValid[t])
				else failRun($sformatf("Result for tag %0d with no operation outstanding", t));
			assert (pendDue[t] == cyc)
				else reportMismatch($sformatf("resultValid cycle of tag %0d", t), pendDue[t], cyc);
			assert (resultData == pendData[t])
				else reportMismatch("resultData", pendData[t], resultData);
			for (int i = 0; i < 16; i++)
				if (pendValid[i] && pendSeq[i] < pendSeq[t])
					sawReorder = 1'b1;		// Older op still in flight
			pendValid[t] = 1'b0;
		end
		for (int i = 0; i < 16; i++)
			assert (!(pendValid[i] && pendDue[i] <= cyc))
				else failRun($sformatf("Result for tag %0d never arrived", i));
	endtask

	task automatic cycleOp(input logic strobe, input maOp op, input maData a, input maData b,
			input maData c, output logic taken);
		int lat;
		int entry;
		logic useAdder;
		logic wantBusy;
		@(negedge clock);
		cyc++;
		checkResults();
		opStrobe = strobe;
		opCode = op;
		opA = a;
		opB = b;
		opC = c;
		#1;								// Let busy settle
		lat = latencyOf(op);
		entry = (op == opMad) ? DEPTH_MLT : 0;
		useAdder = (op != opMul);
		wantBusy = strobe && ((useAdder && addTaken.exists(cyc + entry))
			|| resTaken.exists(cyc + lat));
		assert (busy == wantBusy) else reportMismatch("busy", wantBusy, busy);
		taken = strobe && !busy;
		if (taken) begin
			assert (issueTag == nextTag) else reportMismatch("issueTag", nextTag, issueTag);
			assert (!pendValid[issueTag])
				else failRun("Issue tag reused while its result is outstanding");
			if (useAdder)
				addTaken[cyc + entry] = 1'b1;
			resTaken[cyc + lat] = 1'b1;
			pendValid[issueTag] = 1'b1;
			pendData[issueTag] = expectedResult(op, a, b, c);
			pendDue[issueTag] = cyc + lat + 1;		// Seen at the negedge after the result edge
			pendSeq[issueTag] = seqCnt++;
			nextTag = maTag'(nextTag + 1'b1);
		end
	endtask

	// Holds the operation until the unit takes it
	task automatic issueOp(input maOp op, input maData a, input maData b, input maData c,
			output int held);
		logic taken;
		held = 0;
		cycleOp(1'b1, op, a, b, c, taken);
		while (!taken) begin
			held++;
			cycleOp(1'b1, op, a, b, c, taken);
		end
	endtask

	////////////////////////////////////////
	// Stimulus

	initial begin
		logic taken;
		int held;
		logic [31:0] r;
		maData a;
		maData b;
		maData c;
		arstN = 1'b0;
		opStrobe = 1'b0;
		opCode = opAdd;
		opA = '0;
		opB = '0;
		opC = '0;
		repeat (16) @(negedge clock);
		assert (busy == 1'b0) else reportMismatch("busy", 0, busy);
		assert (resultValid == 1'b0) else reportMismatch("resultValid", 0, resultValid);
		assert (issueTag == '0) else reportMismatch("issueTag", 0, issueTag);
		arstN = 1'b1;

		// Two multiply-adds, then an add landing on the first one's adder slot
		issueOp(opMad, 16'h0003, 16'h0005, 16'h0007, held);
		issueOp(opMad, 16'hffff, 16'h0002, 16'h0010, held);
		repeat (DEPTH_MLT - 2) cycleOp(1'b0, opAdd, '0, '0, '0, taken);
		issueOp(opAdd, 16'hfff0, 16'h0020, '0, held);
		assert (held > 0) else failRun("Busy did not rise for an add colliding with a multiply-add");
		issueOp(opAdd, 16'h1234, 16'h1111, '0, held);

		// Add right behind a multiply finishes first
		issueOp(opMul, 16'h0100, 16'h0101, '0, held);
		issueOp(opSub, 16'h0001, 16'h0002, '0, held);

		for (int k = 0; k < NUM_OPS; k++) begin
			r = $random(seed);
			if (r[4:2] == 3'd0)
				cycleOp(1'b0, opAdd, '0, '0, '0, taken);	// Idle gap
			a = $random(seed);
			b = $random(seed);
			c = $random(seed);
			issueOp(maOp'(r[1:0]), a, b, c, held);
		end

		repeat (DEPTH_MLT + DEPTH_ADD + 4) cycleOp(1'b0, opAdd, '0, '0, '0, taken);
		if (!sawReorder) begin
			failRun("No out-of-order completion was observed");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		failRun("Watchdog expired before the test sequence finished");
	end

endmodule

// File: compile.f
src/maPkg.sv
src/maLaneIf.sv
src/maIssue.sv
src/maOperandRing.sv
src/maMultPipe.sv
src/maAddPipe.sv
src/maResultSelect.sv
src/maUnit.sv
verification/maUnitTb.sv

// File: Bender.yml
package:
  name: ma_unit

sources:
  - files:
      - src/maPkg.sv
      - src/maLaneIf.sv
      - src/maIssue.sv
      - src/maOperandRing.sv
      - src/maMultPipe.sv
      - src/maAddPipe.sv
      - src/maResultSelect.sv
      - src/maUnit.sv
  - target: test
    files:
      - verification/maUnitTb.sv
